/* ising_params.svh */
// ising core sizing
// spin count, index width and the signed widths used in the field sum

`ifndef ISING_PARAMS_SVH
`define ISING_PARAMS_SVH

// number of spins, at most 16 because the command index fields are 4 bits wide
`define ISING_N 16

// spin index width
`define ISING_IDX_W $clog2(`ISING_N)

// signed coupling weight and signed bias widths
`define ISING_J_W 4
`define ISING_H_W 6

// signed local field, holds N*8+32 in magnitude
`define ISING_FIELD_W 10

// sweep count carried by a START command
`define ISING_SWEEP_W 8

`endif

/* ising_pkg.sv */
// ising core command types
// a 32-bit host command word with the 2-bit opcode at the top, seen in four ways

`include "ising_params.svh"

package ising_pkg;

  typedef enum logic [1:0] {
    OP_WR_J    = 2'd0,
    OP_WR_H    = 2'd1,
    OP_LD_SPIN = 2'd2,
    OP_START   = 2'd3
  } ising_op_e;

  typedef struct packed {
    ising_op_e                        op;
    logic [3:0]                       row;
    logic [3:0]                       col;
    logic [`ISING_J_W-1:0]            weight; // two's complement
    logic [32-2-8-`ISING_J_W-1:0]     pad;
  } ising_wr_j_t;

  typedef struct packed {
    ising_op_e                        op;
    logic [3:0]                       idx;
    logic [`ISING_H_W-1:0]            bias;   // two's complement
    logic [32-2-4-`ISING_H_W-1:0]     pad;
  } ising_wr_h_t;

  typedef struct packed {
    ising_op_e                        op;
    logic [15:0]                      spins;  // bit i is spin i, only the low N bits are used
    logic [13:0]                      pad;
  } ising_ld_spin_t;

  typedef struct packed {
    ising_op_e                        op;
    logic [`ISING_SWEEP_W-1:0]        sweeps;
    logic [32-2-`ISING_SWEEP_W-1:0]   pad;
  } ising_start_t;

  // the op field sits at the same place in every view
  typedef union packed {
    ising_wr_j_t    wr_j;
    ising_wr_h_t    wr_h;
    ising_ld_spin_t ld_spin;
    ising_start_t   start;
  } ising_cmd_u;

endpackage

/* ising_row_if.sv */
// ising row read interface
// control names a spin, the memory returns its J row and bias one cycle later,
// and the field unit flags the sign decision one cycle after that

`include "ising_params.svh"

interface ising_row_if;

  logic [`ISING_IDX_W-1:0]             addr;           // spin being updated
  logic                                spin_idx_valid; // addr is a read request this cycle
  logic [`ISING_N-1:0][`ISING_J_W-1:0] j_row;          // J[addr][j] for every j
  logic signed [`ISING_H_W-1:0]        h_val;          // h[addr]
  logic                                field_valid;    // new spin bit is being written

  modport ctrl (
    output addr,
    output spin_idx_valid,
    input  field_valid
  );

  modport mem (
    input  addr,
    input  spin_idx_valid,
    output j_row,
    output h_val
  );

  modport field (
    input  addr,
    input  spin_idx_valid,
    input  j_row,
    input  h_val,
    output field_valid
  );

endinterface

/* ising_ctrl.sv */
// ising core control
// decodes host commands while idle and walks the spins in index order,
// three cycles per spin, for the requested number of sweeps

`include "ising_params.svh"

module ising_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cmd_valid_i,
  input  ising_pkg::ising_cmd_u cmd_i,
  ising_row_if.ctrl             row,
  output logic                  j_we_o,
  output logic                  h_we_o,
  output logic                  spin_ld_o,
  output logic                  busy_o,
  output logic                  done_o
);

  import ising_pkg::*;

  localparam int unsigned IDX_W    = `ISING_IDX_W;
  localparam int unsigned LAST_IDX = `ISING_N - 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE, // address cycle
    S_WAIT,  // row read cycle
    S_NEXT   // field and write cycle, advances spin and sweep
  } state_e;

  state_e                    state_q;
  logic [IDX_W-1:0]          spin_q;
  logic [`ISING_SWEEP_W-1:0] sweep_q; // sweeps still to run, including the current one
  logic                      busy_q;
  logic                      done_q;
  logic                      cmd_ok;
  logic                      last_spin;
  logic                      last_sweep;

  assign cmd_ok    = cmd_valid_i && (state_q == S_IDLE); // anything else is dropped
  assign j_we_o    = cmd_ok && (cmd_i.wr_j.op == OP_WR_J);
  assign h_we_o    = cmd_ok && (cmd_i.wr_j.op == OP_WR_H);
  assign spin_ld_o = cmd_ok && (cmd_i.wr_j.op == OP_LD_SPIN);

  assign last_spin  = (spin_q == LAST_IDX[IDX_W-1:0]);
  assign last_sweep = (sweep_q == `ISING_SWEEP_W'(1));

  assign row.addr           = spin_q;
  assign row.spin_idx_valid = (state_q == S_ISSUE);

  assign busy_o = busy_q;
  assign done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      spin_q  <= '0;
      sweep_q <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (cmd_ok && (cmd_i.start.op == OP_START)) begin
            if (cmd_i.start.sweeps == '0) begin
              done_q <= 1'b1; // nothing to run, report at once
            end else begin
              state_q <= S_ISSUE;
              spin_q  <= '0;
              sweep_q <= cmd_i.start.sweeps;
              busy_q  <= 1'b1;
            end
          end
        end
        S_ISSUE: state_q <= S_WAIT;
        S_WAIT: begin
          state_q <= S_NEXT;
          // done lines up with the write cycle of the very last spin
          if (last_spin && last_sweep) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
        S_NEXT: begin
          if (row.field_valid) begin
            if (last_spin) begin
              spin_q  <= '0;
              sweep_q <= sweep_q - `ISING_SWEEP_W'(1);
              state_q <= last_sweep ? S_IDLE : S_ISSUE;
            end else begin
              spin_q  <= spin_q + IDX_W'(1);
              state_q <= S_ISSUE;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // a row request outside a run would clobber the row the field unit holds
  a_issue_only_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) row.spin_idx_valid |-> busy_o
  ) else $error("spin_idx_valid raised while not busy");

endmodule

/* ising_j_mem.sv */
// ising coupling and bias storage
// N x N weights and N biases written one entry per host command,
// with a registered read of one spin's row and bias

`include "ising_params.svh"

module ising_j_mem (
  input  logic                  clk_i,
  input  logic                  we_j_i,
  input  logic                  we_h_i,
  input  ising_pkg::ising_cmd_u cmd_i,
  ising_row_if.mem              row
);

  localparam int unsigned IDX_W = `ISING_IDX_W;

  logic [`ISING_N-1:0][`ISING_J_W-1:0] j_mem [`ISING_N]; // j_mem[i][j] is J_ij
  logic [`ISING_H_W-1:0]               h_mem [`ISING_N];

  // host writes, decoded from the command views
  always_ff @(posedge clk_i) begin
    if (we_j_i) begin
      j_mem[cmd_i.wr_j.row[IDX_W-1:0]][cmd_i.wr_j.col[IDX_W-1:0]] <= cmd_i.wr_j.weight;
    end
    if (we_h_i) begin
      h_mem[cmd_i.wr_h.idx[IDX_W-1:0]] <= cmd_i.wr_h.bias;
    end
  end

  always_ff @(posedge clk_i) begin
    if (row.spin_idx_valid) begin
      row.j_row <= j_mem[row.addr];
      row.h_val <= h_mem[row.addr]; // field unit sign extends
    end
  end

  // host commands only pass while idle, so they never meet a row read
  a_no_rw_clash: assert property (
    @(posedge clk_i) !((we_j_i || we_h_i) && row.spin_idx_valid)
  ) else $error("J or h write in the same cycle as a row read");

endmodule

/* ising_field_unit.sv */
// ising local field unit
// sums h_i and +/-J_ij over j != i with an adder tree, then registers the
// new spin bit, keeping the old bit when the field is exactly zero

`include "ising_params.svh"

module ising_field_unit (
  input  logic                    clk_i,
  input  logic                    rst_i,
  ising_row_if.field              row,
  input  logic [`ISING_N-1:0]     spins_i,
  output logic                    upd_o,
  output logic [`ISING_IDX_W-1:0] upd_idx_o,
  output logic                    upd_bit_o
);

  localparam int unsigned N     = `ISING_N;
  localparam int unsigned IDX_W = `ISING_IDX_W;
  localparam int unsigned FW    = `ISING_FIELD_W;
  localparam int unsigned LVLS  = $clog2(`ISING_N);

  logic [IDX_W-1:0]     idx_q;      // spin whose row is on row.j_row
  logic                 row_vld_q;
  logic signed [FW-1:0] tree [LVLS+1][N];
  logic signed [FW-1:0] field;
  logic                 new_bit;
  logic                 upd_q;
  logic [IDX_W-1:0]     upd_idx_q;
  logic                 upd_bit_q;

  always_comb begin
    for (int l = 0; l <= int'(LVLS); l++) begin
      for (int k = 0; k < int'(N); k++) begin
        tree[l][k] = '0;
      end
    end
    // leaf j contributes J_ij*s_j, the diagonal is skipped
    for (int j = 0; j < int'(N); j++) begin
      if (j != int'(idx_q)) begin
        tree[0][j] = spins_i[j] ? FW'($signed(row.j_row[j])) : -FW'($signed(row.j_row[j]));
      end
    end
    for (int l = 0; l < int'(LVLS); l++) begin
      for (int k = 0; k < int'(N >> (l + 1)); k++) begin
        tree[l+1][k] = tree[l][2*k] + tree[l][2*k+1];
      end
    end
  end

  assign field   = tree[LVLS][0] + FW'(row.h_val);
  assign new_bit = (field == '0) ? spins_i[idx_q] : ~field[FW-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      row_vld_q <= 1'b0;
      upd_q     <= 1'b0;
    end else begin
      row_vld_q <= row.spin_idx_valid; // row arrives one cycle after the request
      upd_q     <= row_vld_q;
    end
  end

  always_ff @(posedge clk_i) begin
    idx_q     <= row.addr;
    upd_idx_q <= idx_q;
    upd_bit_q <= new_bit;
  end

  assign upd_o           = upd_q;
  assign row.field_valid = upd_q;
  assign upd_idx_o       = upd_idx_q;
  assign upd_bit_o       = upd_bit_q;

endmodule

/* ising_spin_reg.sv */
// ising spin vector
// bulk load from the host and single-spin update from the field unit,
// bit 1 stands for +1 and bit 0 for -1

`include "ising_params.svh"

module ising_spin_reg (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    ld_i,
  input  logic [`ISING_N-1:0]     ld_val_i,
  input  logic                    upd_i,
  input  logic [`ISING_IDX_W-1:0] upd_idx_i,
  input  logic                    upd_bit_i,
  output logic [`ISING_N-1:0]     spins_o
);

  logic [`ISING_N-1:0] spins_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      spins_q <= '0;
    end else if (ld_i) begin
      spins_q <= ld_val_i;
    end else if (upd_i) begin
      spins_q[upd_idx_i] <= upd_bit_i;
    end
  end

  assign spins_o = spins_q;

  // loads are only accepted while idle and updates only happen during a run
  a_ld_upd_excl: assert property (
    @(posedge clk_i) disable iff (rst_i) !(ld_i && upd_i)
  ) else $error("spin load and spin update in the same cycle");

endmodule

/* ising_top.sv */
// ising core top level
// host command strobe in, busy level, done pulse and spin vector out

`include "ising_params.svh"

module ising_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cmd_valid_i,
  input  logic [31:0]         cmd_i,
  output logic                busy_o,
  output logic                done_o,
  output logic [`ISING_N-1:0] spin_o
);

  import ising_pkg::*;

  ising_cmd_u                cmd;
  logic                      j_we;
  logic                      h_we;
  logic                      spin_ld;
  logic                      upd;
  logic [`ISING_IDX_W-1:0]   upd_idx;
  logic                      upd_bit;
  logic [`ISING_N-1:0]       spins;

  assign cmd = cmd_i;

  ising_row_if row_if ();

  ising_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd),
    .row         (row_if.ctrl),
    .j_we_o      (j_we),
    .h_we_o      (h_we),
    .spin_ld_o   (spin_ld),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  ising_j_mem u_j_mem (
    .clk_i  (clk_i),
    .we_j_i (j_we),
    .we_h_i (h_we),
    .cmd_i  (cmd),
    .row    (row_if.mem)
  );

  ising_field_unit u_field (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .row       (row_if.field),
    .spins_i   (spins),
    .upd_o     (upd),
    .upd_idx_o (upd_idx),
    .upd_bit_o (upd_bit)
  );

  ising_spin_reg u_spin_reg (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ld_i      (spin_ld),
    .ld_val_i  (cmd.ld_spin.spins[`ISING_N-1:0]), // low N bits of the load view
    .upd_i     (upd),
    .upd_idx_i (upd_idx),
    .upd_bit_i (upd_bit),
    .spins_o   (spins)
  );

  assign spin_o = spins;

endmodule

/* tb_ising_top.sv */
// testbench for the ising core
// directed tests checked against a software model of the sequential spin update

`include "ising_params.svh"

module tb_ising_top;

  timeunit 1ns;
  timeprecision 1ps;

  import ising_pkg::*;

  localparam int N              = `ISING_N;
  localparam int SWEEP_TOTAL    = 1 + 3 + 1 + 2; // sweeps run by all tests together
  localparam int TIMEOUT_CYCLES = 3 * N * SWEEP_TOTAL + 2000;

  logic         clk_i;
  logic         rst_i;
  logic         cmd_valid_i;
  logic [31:0]  cmd_i;
  logic         busy_o;
  logic         done_o;
  logic [N-1:0] spin_o;

  int           j_ref [N][N]; // model copy of J, j_ref[i][j] is J_ij
  int           h_ref [N];
  logic [N-1:0] s_ref;
  logic [31:0]  lfsr_q;
  int           errors;
  int           checks;
  int           tests_run;

  ising_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .spin_o      (spin_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // watchdog, long enough for every sweep plus all the host writes
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("done_o came %0d cycles after START instead of %0d", got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errs_before);
  endtask

  task automatic send_cmd(input ising_cmd_u c);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_i       <= c;
  endtask

  task automatic idle_bus();
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic write_j(input int r, input int c, input logic [3:0] w);
    ising_cmd_u cmd;
    cmd             = '0;
    cmd.wr_j.op     = OP_WR_J;
    cmd.wr_j.row    = 4'(r);
    cmd.wr_j.col    = 4'(c);
    cmd.wr_j.weight = w;
    send_cmd(cmd);
    j_ref[r][c] = int'($signed(w));
  endtask

  task automatic write_h(input int i, input logic [5:0] b);
    ising_cmd_u cmd;
    cmd           = '0;
    cmd.wr_h.op   = OP_WR_H;
    cmd.wr_h.idx  = 4'(i);
    cmd.wr_h.bias = b;
    send_cmd(cmd);
    h_ref[i] = int'($signed(b));
  endtask

  task automatic load_spins(input logic [N-1:0] pat);
    ising_cmd_u cmd;
    cmd               = '0;
    cmd.ld_spin.op    = OP_LD_SPIN;
    cmd.ld_spin.spins = 16'(pat);
    send_cmd(cmd);
    s_ref = pat;
  endtask

  task automatic fill_random_problem();
    logic [31:0] r;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        r = take_bits(`ISING_J_W);
        write_j(i, j, r[3:0]);
      end
    end
    for (int i = 0; i < N; i++) begin
      r = take_bits(`ISING_H_W);
      write_h(i, r[5:0]);
    end
  endtask

  // spins in index order, each takes the sign of h_i + sum J_ij*s_j, zero keeps it
  task automatic model_sweeps(input int sweeps);
    int field;
    for (int s = 0; s < sweeps; s++) begin
      for (int i = 0; i < N; i++) begin
        field = h_ref[i];
        for (int j = 0; j < N; j++) begin
          if (j != i) field += s_ref[j] ? j_ref[i][j] : -j_ref[i][j];
        end
        if (field > 0) s_ref[i] = 1'b1;
        else if (field < 0) s_ref[i] = 1'b0;
      end
    end
  endtask

  // counts edges from the START edge until done_o shows, the watchdog bounds it
  task automatic wait_done(output int n);
    n = 0;
    do begin
      @(posedge clk_i);
      cmd_valid_i <= 1'b0;
      n++;
      @(negedge clk_i);
    end while (!done_o);
  endtask

  task automatic start_cmd(input int sweeps, output ising_cmd_u cmd);
    cmd              = '0;
    cmd.start.op     = OP_START;
    cmd.start.sweeps = 8'(sweeps);
  endtask

  task automatic run_sweeps(input int sweeps);
    ising_cmd_u cmd;
    int         n;
    start_cmd(sweeps, cmd);
    send_cmd(cmd);
    wait_done(n);
    check_latency(n, 3 * N * sweeps);
    check_value("busy_o", 32'(busy_o), 32'd0); // falls with the done pulse
    @(negedge clk_i);
    check_value("done_o", 32'(done_o), 32'd0);
    model_sweeps(sweeps);
    check_value("spin_o", 32'(spin_o), 32'(s_ref));
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    @(negedge clk_i);
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("done_o", 32'(done_o), 32'd0);
    check_value("spin_o", 32'(spin_o), 32'd0);
    report_test("reset state", e0);
  endtask

  task automatic spin_load();
    int e0;
    e0 = errors;
    load_spins(N'(take_bits(N)));
    idle_bus();
    @(negedge clk_i);
    check_value("spin_o", 32'(spin_o), 32'(s_ref));
    report_test("spin load", e0);
  endtask

  task automatic ferro_sweep();
    int e0;
    e0 = errors;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) write_j(i, j, 4'h1);
      write_h(i, 6'h00);
    end
    load_spins(N'(take_bits(N)));
    run_sweeps(1);
    report_test("ferromagnetic sweep", e0);
  endtask

  task automatic random_anneal();
    int e0;
    e0 = errors;
    fill_random_problem();
    load_spins(N'(take_bits(N)));
    run_sweeps(3);
    report_test("random three sweeps", e0);
  endtask

  task automatic forced_pattern();
    int           e0;
    logic [N-1:0] alt;
    e0 = errors;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) write_j(i, j, 4'h0);
      write_h(i, (i % 2 == 0) ? 6'h1f : 6'h20); // +31 on even spins, -32 on odd
      alt[i] = (i % 2 == 0);
    end
    load_spins(N'(take_bits(N)));
    run_sweeps(1);
    check_value("spin_o", 32'(spin_o), 32'(alt));
    report_test("bias forced pattern", e0);
  endtask

  task automatic dropped_load();
    int         e0;
    int         n;
    ising_cmd_u cmd;
    e0 = errors;
    fill_random_problem();
    load_spins(N'(take_bits(N)));
    start_cmd(2, cmd);
    send_cmd(cmd);
    cmd               = '0;
    cmd.ld_spin.op    = OP_LD_SPIN;
    cmd.ld_spin.spins = 16'(take_bits(N));
    send_cmd(cmd); // presented while the run is active
    @(negedge clk_i);
    check_value("busy_o", 32'(busy_o), 32'd1);
    wait_done(n);
    check_latency(n, 3 * N * 2 - 1); // the count starts one edge after START was taken
    @(negedge clk_i); // last spin is written on the edge after the done pulse
    model_sweeps(2);
    check_value("spin_o", 32'(spin_o), 32'(s_ref));
    report_test("load while busy", e0);
  endtask

  initial begin
    lfsr_q      = 32'ha7a0;
    errors      = 0;
    checks      = 0;
    tests_run   = 0;
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    reset_state();
    spin_load();
    ferro_sweep();
    random_anneal();
    forced_pattern();
    dropped_load();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
ising_pkg.sv
ising_row_if.sv
ising_ctrl.sv
ising_j_mem.sv
ising_field_unit.sv
ising_spin_reg.sv
ising_top.sv
tb_ising_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the ising core testbench with Verilator, run it and scan the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_ising_top -Mdir obj_dir -o sim_ising

./obj_dir/sim_ising | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
